// ==== logic/dbg_mon_pkg.sv ====
/*
  Types and constants shared by the debug-entry monitor.
  XLEN is fixed at 32, and retired words are compared in full, with no masking.
  Register offsets are byte addresses on the APB side.
*/
`default_nettype none

package dbg_mon_pkg;

  parameter int XLEN = 32;

  // ----------------------------------------------------------
  // Retired instruction classes
  // ----------------------------------------------------------
  typedef enum logic [2:0] {
    KIND_OTHER   = 3'd0,
    KIND_EBREAK  = 3'd1,
    KIND_CEBREAK = 3'd2,
    KIND_WFI     = 3'd3,
    KIND_DRET    = 3'd4,
    KIND_ECALL   = 3'd5
  } instr_kind_e;

  // Debug cause codes as reported in STATUS[2:0]
  typedef enum logic [2:0] {
    CAUSE_NONE    = 3'd0,
    CAUSE_EBREAK  = 3'd1,
    CAUSE_TRIGGER = 3'd2,
    CAUSE_HALTREQ = 3'd3,
    CAUSE_STEP    = 3'd4
  } dbg_cause_e;

  typedef enum logic [1:0] {
    ST_RUN   = 2'd0,
    ST_SLEEP = 2'd1,
    ST_DEBUG = 2'd2
  } mon_state_e;

  // ----------------------------------------------------------
  // Instruction encodings
  // ----------------------------------------------------------
  parameter logic [XLEN-1:0] EBREAK_INSTR  = 32'h0010_0073;
  // c.ebreak sits in the low half, upper half zero
  parameter logic [XLEN-1:0] CEBREAK_INSTR = 32'h0000_9002;
  parameter logic [XLEN-1:0] WFI_INSTR     = 32'h1050_0073;
  parameter logic [XLEN-1:0] DRET_INSTR    = 32'h7B20_0073;
  parameter logic [XLEN-1:0] ECALL_INSTR   = 32'h0000_0073;

  // ----------------------------------------------------------
  // Register map
  // ----------------------------------------------------------
  parameter logic [7:0] REG_CTRL      = 8'h00;
  parameter logic [7:0] REG_TDATA2    = 8'h04;
  parameter logic [7:0] REG_STATUS    = 8'h08;
  parameter logic [7:0] REG_DPC       = 8'h0C;
  parameter logic [7:0] REG_EBREAK_PC = 8'h10;
  parameter logic [7:0] REG_EXC_COUNT = 8'h14;

  // Bit positions inside CTRL
  parameter int CTRL_EBREAKM_BIT = 0;
  parameter int CTRL_STEP_BIT    = 1;
  parameter int CTRL_TRIG_EN_BIT = 2;

endpackage

`default_nettype wire

// ==== logic/dbg_mon_if.sv ====
/*
  Interfaces between the monitor blocks.
  retire_class_if has no back-pressure, so the tracker must take one event per cycle.
  The CNT_W of dbg_cfg_if must match the CNT_W of the tracker.
*/
`default_nettype none

// Classified retire event, valid for a single cycle
interface retire_class_if;
  import dbg_mon_pkg::*;

  logic            ev_valid;
  instr_kind_e     kind;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] next_pc;
  logic            addr_match;

  modport src (output ev_valid, output kind, output pc, output next_pc, output addr_match);
  modport dst (input ev_valid, input kind, input pc, input next_pc, input addr_match);
endinterface

// ----------------------------------------------------------
// Configuration out, tracker status back
// ----------------------------------------------------------
interface dbg_cfg_if #(
  parameter int CNT_W = 16
);
  import dbg_mon_pkg::*;

  logic             ebreakm;
  logic             step;
  logic             trig_en;
  logic [XLEN-1:0]  tdata2;
  mon_state_e       state;
  dbg_cause_e       cause;
  logic [XLEN-1:0]  dpc;
  logic [XLEN-1:0]  ebreak_pc;
  logic [CNT_W-1:0] exc_count;

  modport regs (
    output ebreakm, output step, output trig_en, output tdata2,
    input  state, input cause, input dpc, input ebreak_pc, input exc_count
  );
  modport tracker (
    input  ebreakm, input step,
    output state, output cause, output dpc, output ebreak_pc, output exc_count
  );
  // Trigger match only needs the enable and the address
  modport cfg (input trig_en, input tdata2);
endinterface

`default_nettype wire

// ==== logic/instr_decode.sv ====
/*
  Classifies each retired instruction and registers it as one event.
  A retire with ret_err_i set is dropped.
  The trigger is an exact PC match on tdata2, qualified by trig_en.
*/
`default_nettype none

module instr_decode (
  input  logic                         cov_assert_if,
  input  logic                         rst_n_i,
  input  logic                         ret_valid_i,
  input  logic                         ret_err_i,
  input  logic [dbg_mon_pkg::XLEN-1:0] ret_instr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0] ret_pc_i,
  dbg_cfg_if.cfg                       cfg,
  retire_class_if.src                  ev
);
  import dbg_mon_pkg::*;

  instr_kind_e     kind_d;
  logic [XLEN-1:0] pc_step;
  logic            match_d;
  logic            take;

  // Full-word compare against the known encodings
  always_comb begin
    case (ret_instr_i)
      EBREAK_INSTR:  kind_d = KIND_EBREAK;
      CEBREAK_INSTR: kind_d = KIND_CEBREAK;
      WFI_INSTR:     kind_d = KIND_WFI;
      DRET_INSTR:    kind_d = KIND_DRET;
      ECALL_INSTR:   kind_d = KIND_ECALL;
      default:       kind_d = KIND_OTHER;
    endcase
  end

  // Only c.ebreak is 16 bits wide here
  assign pc_step = (kind_d == KIND_CEBREAK) ? XLEN'(2) : XLEN'(4);
  assign match_d = cfg.trig_en && (ret_pc_i == cfg.tdata2);
  assign take    = ret_valid_i && !ret_err_i;

  // ----------------------------------------------------------
  // Event register
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      ev.ev_valid <= 1'b0;
    end else begin
      ev.ev_valid <= take;
    end
  end

  // Payload is only looked at while ev_valid is high
  always_ff @(posedge cov_assert_if) begin
    if (take) begin
      ev.kind       <= kind_d;
      ev.pc         <= ret_pc_i;
      ev.next_pc    <= ret_pc_i + pc_step;
      ev.addr_match <= match_d;
    end
  end

endmodule

`default_nettype wire

// ==== logic/cause_tracker.sv ====
/*
  Run, sleep and debug FSM of the monitor.
  Entry priority is trigger, then ebreak with ebreakm, then halt request, then step.
  Causes are not re-evaluated in debug mode. Only dret leaves it.
  The exception counter saturates at all ones.
*/
`default_nettype none

module cause_tracker #(
  parameter int CNT_W = 16
) (
  input  logic        cov_assert_if,
  input  logic        rst_n_i,
  input  logic        debug_req_i,
  input  logic        irq_i,
  retire_class_if.dst ev,
  dbg_cfg_if.tracker  cfg,
  output logic        debug_mode_o,
  output logic        sleep_o
);
  import dbg_mon_pkg::*;

  mon_state_e       state_q;
  dbg_cause_e       cause_q;
  logic [XLEN-1:0]  dpc_q;
  logic [XLEN-1:0]  ebreak_pc_q;
  logic [XLEN-1:0]  last_npc_q;
  logic [CNT_W-1:0] exc_q;
  logic             is_ebreak;
  logic             is_wfi;
  logic             is_dret;
  dbg_cause_e       run_cause;
  logic [XLEN-1:0]  run_dpc;

  assign is_ebreak = ev.ev_valid && ((ev.kind == KIND_EBREAK) || (ev.kind == KIND_CEBREAK));
  assign is_wfi    = ev.ev_valid && (ev.kind == KIND_WFI);
  assign is_dret   = ev.ev_valid && (ev.kind == KIND_DRET);

  // ----------------------------------------------------------
  // Entry cause while running
  // ----------------------------------------------------------
  always_comb begin
    run_cause = CAUSE_NONE;
    run_dpc   = last_npc_q;
    if (ev.ev_valid) begin
      if (ev.addr_match) begin
        run_cause = CAUSE_TRIGGER;
        run_dpc   = ev.pc;
      end else if (is_ebreak && cfg.ebreakm) begin
        run_cause = CAUSE_EBREAK;
        run_dpc   = ev.pc;
      end else if (debug_req_i) begin
        run_cause = CAUSE_HALTREQ;
        run_dpc   = ev.next_pc;
      end else if (cfg.step) begin
        // ecall and other retires end up here too
        run_cause = CAUSE_STEP;
        run_dpc   = ev.next_pc;
      end
    end else if (debug_req_i) begin
      // No retire this cycle, so resume where the core would go next
      run_cause = CAUSE_HALTREQ;
    end
  end

  // ----------------------------------------------------------
  // State and captures
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      state_q     <= ST_RUN;
      cause_q     <= CAUSE_NONE;
      dpc_q       <= '0;
      ebreak_pc_q <= '0;
      last_npc_q  <= '0;
      exc_q       <= '0;
    end else begin
      if (is_ebreak) begin
        ebreak_pc_q <= ev.pc;
      end
      case (state_q)
        ST_RUN: begin
          if (ev.ev_valid) begin
            last_npc_q <= ev.next_pc;
          end
          if (run_cause != CAUSE_NONE) begin
            state_q <= ST_DEBUG;
            cause_q <= run_cause;
            dpc_q   <= run_dpc;
          end else if (is_ebreak) begin
            // Breakpoint exception, the core keeps running
            if (exc_q != {CNT_W{1'b1}}) begin
              exc_q <= exc_q + 1'b1;
            end
          end else if (is_wfi) begin
            state_q <= ST_SLEEP;
          end
        end
        ST_SLEEP: begin
          if (debug_req_i) begin
            state_q <= ST_DEBUG;
            cause_q <= CAUSE_HALTREQ;
            dpc_q   <= last_npc_q;
          end else if (irq_i) begin
            state_q <= ST_RUN;
          end
        end
        ST_DEBUG: begin
          // wfi and ebreak keep debug mode, an ebreak only moves ebreak_pc
          if (is_dret) begin
            state_q    <= ST_RUN;
            cause_q    <= CAUSE_NONE;
            last_npc_q <= dpc_q;
          end
        end
        default: begin
          state_q <= ST_RUN;
        end
      endcase
    end
  end

  assign debug_mode_o  = (state_q == ST_DEBUG);
  assign sleep_o       = (state_q == ST_SLEEP);
  assign cfg.state     = state_q;
  assign cfg.cause     = cause_q;
  assign cfg.dpc       = dpc_q;
  assign cfg.ebreak_pc = ebreak_pc_q;
  assign cfg.exc_count = exc_q;

endmodule

`default_nettype wire

// ==== logic/dbg_csr_apb.sv ====
/*
  Zero-wait APB slave for the monitor configuration and status.
  pready_o is high in every access cycle.
  An unmapped offset, or a write to a read-only register, gives pslverr_o and no update.
  EXC_COUNT must be no wider than XLEN.
*/
`default_nettype none

module dbg_csr_apb #(
  parameter int APB_ADDR_W = 8
) (
  input  logic                         cov_assert_if,
  input  logic                         rst_n_i,
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [APB_ADDR_W-1:0]        paddr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0] pwdata_i,
  output logic [dbg_mon_pkg::XLEN-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  dbg_cfg_if.regs                      cfg
);
  import dbg_mon_pkg::*;

  logic            access;
  logic            mapped;
  logic            read_only;
  logic            wr_ok;
  logic [2:0]      ctrl_q;
  logic [XLEN-1:0] tdata2_q;
  logic [XLEN-1:0] rdata;

  assign access = psel_i && penable_i;

  // ----------------------------------------------------------
  // Address decode and read mux
  // ----------------------------------------------------------
  always_comb begin
    mapped    = 1'b1;
    read_only = 1'b1;
    rdata     = '0;
    case (paddr_i)
      APB_ADDR_W'(REG_CTRL): begin
        read_only = 1'b0;
        rdata     = XLEN'(ctrl_q);
      end
      APB_ADDR_W'(REG_TDATA2): begin
        read_only = 1'b0;
        rdata     = tdata2_q;
      end
      APB_ADDR_W'(REG_STATUS): begin
        rdata[2:0] = cfg.cause;
        rdata[3]   = (cfg.state == ST_DEBUG);
        rdata[4]   = (cfg.state == ST_SLEEP);
      end
      APB_ADDR_W'(REG_DPC):       rdata = cfg.dpc;
      APB_ADDR_W'(REG_EBREAK_PC): rdata = cfg.ebreak_pc;
      APB_ADDR_W'(REG_EXC_COUNT): rdata = XLEN'(cfg.exc_count);
      default: begin
        mapped    = 1'b0;
        read_only = 1'b0;
      end
    endcase
  end

  assign wr_ok     = access && pwrite_i && mapped && !read_only;
  assign pready_o  = access;
  assign pslverr_o = access && (!mapped || (pwrite_i && read_only));
  assign prdata_o  = rdata;

  // ----------------------------------------------------------
  // Writable registers
  // ----------------------------------------------------------
  always_ff @(posedge cov_assert_if) begin
    if (!rst_n_i) begin
      ctrl_q   <= '0;
      tdata2_q <= '0;
    end else if (wr_ok) begin
      if (paddr_i == APB_ADDR_W'(REG_CTRL)) begin
        ctrl_q <= pwdata_i[2:0];
      end else begin
        // TDATA2 is the only other writable offset
        tdata2_q <= pwdata_i;
      end
    end
  end

  assign cfg.ebreakm = ctrl_q[CTRL_EBREAKM_BIT];
  assign cfg.step    = ctrl_q[CTRL_STEP_BIT];
  assign cfg.trig_en = ctrl_q[CTRL_TRIG_EN_BIT];
  assign cfg.tdata2  = tdata2_q;

endmodule

`default_nettype wire

// ==== logic/dbg_mon_top.sv ====
/*
  Top level of the debug-entry monitor, made of instances and wiring only.
  Retire to debug_mode_o takes 2 cycles, and debug_req_i to debug_mode_o takes 1.
  The APB interface is zero-wait.
*/
`default_nettype none

module dbg_mon_top #(
  parameter int APB_ADDR_W = 8,
  parameter int CNT_W      = 16
) (
  input  logic                         cov_assert_if,
  input  logic                         rst_n_i,
  // Retire stream
  input  logic                         ret_valid_i,
  input  logic [dbg_mon_pkg::XLEN-1:0] ret_instr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0] ret_pc_i,
  input  logic                         ret_err_i,
  input  logic                         debug_req_i,
  input  logic                         irq_i,
  // APB slave
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [APB_ADDR_W-1:0]        paddr_i,
  input  logic [dbg_mon_pkg::XLEN-1:0] pwdata_i,
  output logic [dbg_mon_pkg::XLEN-1:0] prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  output logic                         debug_mode_o,
  output logic                         sleep_o
);

  retire_class_if                ev_if ();
  dbg_cfg_if #(.CNT_W(CNT_W))    cfg_if ();

  // ----------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------
  instr_decode instr_decode_inst (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .ret_valid_i   (ret_valid_i),
    .ret_err_i     (ret_err_i),
    .ret_instr_i   (ret_instr_i),
    .ret_pc_i      (ret_pc_i),
    .cfg           (cfg_if.cfg),
    .ev            (ev_if.src)
  );

  cause_tracker #(
    .CNT_W (CNT_W)
  ) cause_tracker_inst (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .debug_req_i   (debug_req_i),
    .irq_i         (irq_i),
    .ev            (ev_if.dst),
    .cfg           (cfg_if.tracker),
    .debug_mode_o  (debug_mode_o),
    .sleep_o       (sleep_o)
  );

  dbg_csr_apb #(
    .APB_ADDR_W (APB_ADDR_W)
  ) dbg_csr_apb_inst (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .cfg           (cfg_if.regs)
  );

endmodule

`default_nettype wire

// ==== verif/dbg_mon_assertions.sv ====
/*
  Concurrent checks on the tracker FSM, bound into cause_tracker.
  All checks are disabled while rst_n_i is low.
*/
`default_nettype none

module dbg_mon_assertions (
  input logic                    cov_assert_if,
  input logic                    rst_n_i,
  input logic                    debug_mode_i,
  input logic                    sleep_i,
  input dbg_mon_pkg::mon_state_e state_i,
  input dbg_mon_pkg::dbg_cause_e cause_i,
  input logic                    dret_ev_i
);
  import dbg_mon_pkg::*;

  // Number of failed assertions so far
  int fail_count = 0;

  // ----------------------------------------------------------
  // FSM rules
  // ----------------------------------------------------------
  debug_and_sleep_exclusive: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    !(debug_mode_i && sleep_i)
  ) else begin
    fail_count++;
    $error("debug_mode_o and sleep_o are high together");
  end

  // A debug session always carries its entry cause
  debug_has_cause: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    (state_i == ST_DEBUG) |-> (cause_i != CAUSE_NONE)
  ) else begin
    fail_count++;
    $error("Cause is CAUSE_NONE in debug mode");
  end

  dret_leaves_debug: assert property (
    @(posedge cov_assert_if) disable iff (!rst_n_i)
    ((state_i == ST_DEBUG) && dret_ev_i) |=> (state_i == ST_RUN)
  ) else begin
    fail_count++;
    $error("dret in debug mode did not return to ST_RUN");
  end

endmodule

`default_nettype wire

// ==== verif/tb_dbg_mon.sv ====
/*
  Table-driven testbench for the debug-entry monitor.
  Each row writes CTRL and TDATA2, retires one instruction, then drives debug_req
  or irq one cycle later, in the cycle where the classified event reaches the tracker.
  Expected values assume a zero-wait APB slave and a 2-cycle retire latency.
*/
`default_nettype none

module tb_dbg_mon;
  import dbg_mon_pkg::*;

  localparam int APB_ADDR_W  = 8;
  localparam int CNT_W       = 16;
  localparam int APB_TIMEOUT = 20;

  // One stimulus row with its expected results
  typedef struct packed {
    logic [2:0]  ctrl;
    logic [31:0] tdata2;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [2:0]  drv;     // {retire, debug_req, irq}
    logic [1:0]  st;      // {debug_mode, sleep}
    logic [2:0]  cause;
    logic [31:0] dpc;
    logic [31:0] ebpc;
    logic [31:0] cnt;
  } row_t;

  logic                  cov_assert_if;
  logic                  rst_n_i;
  logic                  ret_valid_i;
  logic [XLEN-1:0]       ret_instr_i;
  logic [XLEN-1:0]       ret_pc_i;
  logic                  ret_err_i;
  logic                  debug_req_i;
  logic                  irq_i;
  logic                  psel_i;
  logic                  penable_i;
  logic                  pwrite_i;
  logic [APB_ADDR_W-1:0] paddr_i;
  logic [XLEN-1:0]       pwdata_i;
  logic [XLEN-1:0]       prdata_o;
  logic                  pready_o;
  logic                  pslverr_o;
  logic                  debug_mode_o;
  logic                  sleep_o;

  row_t   rows[$];
  integer seed = 27;
  int     err_cnt = 0;
  int     tests_run = 0;
  int     tests_failed = 0;

  dbg_mon_top #(.APB_ADDR_W(APB_ADDR_W), .CNT_W(CNT_W)) dbg_mon_top_inst (.*);

  bind cause_tracker dbg_mon_assertions assertions_inst (
    .cov_assert_if (cov_assert_if),
    .rst_n_i       (rst_n_i),
    .debug_mode_i  (debug_mode_o),
    .sleep_i       (sleep_o),
    .state_i       (state_q),
    .cause_i       (cause_q),
    .dret_ev_i     (is_dret)
  );

  initial begin
    cov_assert_if = 1'b0;
    forever #50 cov_assert_if = ~cov_assert_if;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic step_cycle();
    @(posedge cov_assert_if);
    #10;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  // All monitored encodings have bit 31 clear
  function automatic logic [31:0] random_other();
    logic [31:0] w;
    w = $random(seed);
    return {1'b1, w[30:0]};
  endfunction

  function automatic void add_row(input logic [2:0] ctrl, input logic [31:0] tdata2,
                                  input logic [31:0] instr, input logic [31:0] pc,
                                  input logic [2:0] drv, input logic [1:0] st,
                                  input logic [2:0] cause, input logic [31:0] dpc,
                                  input logic [31:0] ebpc, input logic [31:0] cnt);
    rows.push_back(row_t'{ctrl, tdata2, instr, pc, drv, st, cause, dpc, ebpc, cnt});
  endfunction

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (err_cnt == errs_before) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d check(s) failed", name, err_cnt - errs_before);
    end
  endtask

  // ----------------------------------------------------------
  // APB master
  // ----------------------------------------------------------
  task automatic apb_xfer(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output logic err);
    int waited;
    waited    = 0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    step_cycle();
    penable_i = 1'b1;
    #20;
    while (!pready_o) begin
      if (waited == APB_TIMEOUT) begin
        $display("No pready_o within %0d cycles for APB offset 0x%02h", APB_TIMEOUT, addr);
        $display("Testbench failed");
        $finish;
      end else begin
        waited++;
        step_cycle();
        #20;
      end
    end
    rdata = prdata_o;
    err   = pslverr_o;
    step_cycle();
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
    logic [31:0] unused_rd;
    logic        err;
    apb_xfer(1'b1, addr, data, unused_rd, err);
    check("pslverr_o", 32'(err), 32'd0);
  endtask

  task automatic apb_read(input logic [APB_ADDR_W-1:0] addr, output logic [31:0] data);
    logic err;
    apb_xfer(1'b0, addr, 32'd0, data, err);
    check("pslverr_o", 32'(err), 32'd0);
  endtask

  task automatic apply_row(input row_t r);
    logic [31:0] rd;
    apb_write(REG_CTRL, 32'(r.ctrl));
    apb_write(REG_TDATA2, r.tdata2);
    ret_valid_i = r.drv[2];
    ret_instr_i = r.instr;
    ret_pc_i    = r.pc;
    step_cycle();
    // Request and wake-up line up with the registered event
    ret_valid_i = 1'b0;
    debug_req_i = r.drv[1];
    irq_i       = r.drv[0];
    step_cycle();
    debug_req_i = 1'b0;
    irq_i       = 1'b0;
    check("debug_mode_o", 32'(debug_mode_o), 32'(r.st[1]));
    check("sleep_o", 32'(sleep_o), 32'(r.st[0]));
    apb_read(REG_STATUS, rd);
    check("STATUS", rd, 32'({r.st[0], r.st[1], r.cause}));
    apb_read(REG_DPC, rd);
    check("DPC", rd, r.dpc);
    apb_read(REG_EBREAK_PC, rd);
    check("EBREAK_PC", rd, r.ebpc);
    apb_read(REG_EXC_COUNT, rd);
    check("EXC_COUNT", rd, r.cnt);
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic        err;
    int          errs_before;
    int          assert_fails;
    rst_n_i     = 1'b0;
    ret_valid_i = 1'b0;
    ret_instr_i = '0;
    ret_pc_i    = '0;
    ret_err_i   = 1'b0;
    debug_req_i = 1'b0;
    irq_i       = 1'b0;
    psel_i      = 1'b0;
    penable_i   = 1'b0;
    pwrite_i    = 1'b0;
    paddr_i     = '0;
    pwdata_i    = '0;
    repeat (5) step_cycle();
    rst_n_i = 1'b1;

    errs_before = err_cnt;
    check("debug_mode_o", 32'(debug_mode_o), 32'd0);
    check("sleep_o", 32'(sleep_o), 32'd0);
    check("pready_o", 32'(pready_o), 32'd0);
    check("pslverr_o", 32'(pslverr_o), 32'd0);
    end_test("reset", errs_before);

    errs_before = err_cnt;
    apb_write(REG_CTRL, 32'h5);
    apb_read(REG_CTRL, rd);
    check("CTRL", rd, 32'h5);
    apb_write(REG_TDATA2, 32'hCAFE_0010);
    apb_read(REG_TDATA2, rd);
    check("TDATA2", rd, 32'hCAFE_0010);
    apb_xfer(1'b1, REG_STATUS, 32'h1F, rd, err);
    check("pslverr_o on STATUS write", 32'(err), 32'd1);
    apb_xfer(1'b0, 8'h20, 32'd0, rd, err);
    check("pslverr_o on offset 0x20", 32'(err), 32'd1);
    end_test("apb_regs", errs_before);

    // ctrl  tdata2  instr  pc  {ret,req,irq}  {dbg,sleep}  cause  dpc  ebreak_pc  count
    add_row(3'd0, 32'h0, EBREAK_INSTR, 32'h100, 3'b100, 2'b00, 3'd0, 32'h0, 32'h100, 32'd1);
    add_row(3'd1, 32'h0, CEBREAK_INSTR, 32'h200, 3'b100, 2'b10, 3'd1, 32'h200, 32'h200, 32'd1);
    add_row(3'd1, 32'h0, DRET_INSTR, 32'h300, 3'b100, 2'b00, 3'd0, 32'h200, 32'h200, 32'd1);
    add_row(3'd5, 32'h400, EBREAK_INSTR, 32'h400, 3'b100, 2'b10, 3'd2, 32'h400, 32'h400, 32'd1);
    add_row(3'd5, 32'h400, DRET_INSTR, 32'h404, 3'b100, 2'b00, 3'd0, 32'h400, 32'h400, 32'd1);
    add_row(3'd0, 32'h400, EBREAK_INSTR, 32'h400, 3'b100, 2'b00, 3'd0, 32'h400, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, random_other(), 32'h500, 3'b110, 2'b10, 3'd3, 32'h504, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, DRET_INSTR, 32'h600, 3'b100, 2'b00, 3'd0, 32'h504, 32'h400, 32'd2);
    add_row(3'd2, 32'h0, random_other(), 32'h700, 3'b100, 2'b10, 3'd4, 32'h704, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, DRET_INSTR, 32'h800, 3'b100, 2'b00, 3'd0, 32'h704, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, WFI_INSTR, 32'h900, 3'b100, 2'b01, 3'd0, 32'h704, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, 32'h0, 32'h0, 3'b010, 2'b10, 3'd3, 32'h904, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, WFI_INSTR, 32'hA00, 3'b100, 2'b10, 3'd3, 32'h904, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, DRET_INSTR, 32'hA04, 3'b100, 2'b00, 3'd0, 32'h904, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, WFI_INSTR, 32'hB00, 3'b100, 2'b01, 3'd0, 32'h904, 32'h400, 32'd2);
    add_row(3'd0, 32'h0, 32'h0, 32'h0, 3'b001, 2'b00, 3'd0, 32'h904, 32'h400, 32'd2);
    add_row(3'd1, 32'h0, EBREAK_INSTR, 32'hC00, 3'b100, 2'b10, 3'd1, 32'hC00, 32'hC00, 32'd2);
    add_row(3'd1, 32'h0, EBREAK_INSTR, 32'hD00, 3'b100, 2'b10, 3'd1, 32'hC00, 32'hD00, 32'd2);
    add_row(3'd1, 32'h0, DRET_INSTR, 32'hD04, 3'b100, 2'b00, 3'd0, 32'hC00, 32'hD00, 32'd2);
    add_row(3'd2, 32'h0, ECALL_INSTR, 32'hE00, 3'b100, 2'b10, 3'd4, 32'hE04, 32'hD00, 32'd2);
    add_row(3'd0, 32'h0, DRET_INSTR, 32'hF00, 3'b100, 2'b00, 3'd0, 32'hE04, 32'hD00, 32'd2);

    foreach (rows[i]) begin
      errs_before = err_cnt;
      apply_row(rows[i]);
      end_test($sformatf("row %0d", i), errs_before);
    end

    assert_fails = dbg_mon_top_inst.cause_tracker_inst.assertions_inst.fail_count;
    err_cnt += assert_fails;
    $display("Summary: %0d tests, %0d failing, %0d failed checks, %0d assertion failures",
             tests_run, tests_failed, err_cnt - assert_fails, assert_fails);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
logic/dbg_mon_pkg.sv
logic/dbg_mon_if.sv
logic/instr_decode.sv
logic/cause_tracker.sv
logic/dbg_csr_apb.sv
logic/dbg_mon_top.sv
verif/dbg_mon_assertions.sv
verif/tb_dbg_mon.sv

// ==== Makefile ====
# Verilator build and run of the debug-entry monitor testbench

SRCS := $(shell grep -v '^+' filelist.f)

obj_dir/Vtb_dbg_mon: filelist.f $(SRCS)
	verilator --binary --assert -Wno-fatal -j 0 --top-module tb_dbg_mon -f filelist.f

run: obj_dir/Vtb_dbg_mon
	./obj_dir/Vtb_dbg_mon +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^Testbench passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
